// File: common/lcd_pkg.sv
/* Shared definitions for the HD44780 LCD controller:
   clock rate, delay counts in clock cycles, bus types and instruction codes */

`default_nettype none

package lcd_pkg;

	// --------------------------------------------------
	// Clock
	// --------------------------------------------------
	localparam int CLK_HZ     = 24_000_000;           // System clock
	localparam int CYC_PER_US = CLK_HZ / 1_000_000;   // 24 cycles per microsecond

	// --------------------------------------------------
	// Bus types
	// --------------------------------------------------
	typedef logic [7:0]  lcd_byte_t;                  // Instruction code or character
	typedef logic [20:0] delay_t;                     // Wide enough for the 50 ms wait

	// --------------------------------------------------
	// Timing counts in cycles
	// --------------------------------------------------
	// E strobe shape
	localparam delay_t T_SETUP_CYC = delay_t'(CLK_HZ / 4_000_000);   // 250 ns, RS/DB before E
	localparam delay_t T_PULSE_CYC = delay_t'(CLK_HZ / 2_000_000);   // 500 ns of E high

	// Execution waits after E falls
	localparam delay_t T_EXEC_SHORT_CYC = delay_t'(CYC_PER_US * 42);    // 42 us
	localparam delay_t T_EXEC_LONG_CYC  = delay_t'(CYC_PER_US * 1640);  // 1.64 ms, clear and home

	// Power-up and the special init waits
	localparam delay_t T_POWERUP_CYC = delay_t'(CYC_PER_US * 50_000);  // 50 ms after reset
	localparam delay_t T_INIT1_CYC   = delay_t'(CYC_PER_US * 4100);    // After 1st function set
	localparam delay_t T_INIT2_CYC   = delay_t'(CYC_PER_US * 100);     // After 2nd and 3rd

	// --------------------------------------------------
	// Instruction codes
	// --------------------------------------------------
	localparam lcd_byte_t CMD_FUNC_SET = 8'h3C;      // 8-bit bus, 2 lines, 5x11 font
	localparam lcd_byte_t CMD_DISP_OFF = 8'h08;      // Display, cursor, blink off
	localparam lcd_byte_t CMD_CLEAR    = 8'h01;      // Clear display, long exec
	localparam lcd_byte_t CMD_ENTRY    = 8'h06;      // Increment, no shift
	localparam lcd_byte_t CMD_DISP_ON  = 8'h0F;      // Display on with cursor and blink
	localparam lcd_byte_t CMD_HOME     = 8'h02;      // Return home, long exec

	// Length of the power-up instruction table
	localparam int INIT_STEPS = 8;

endpackage

`default_nettype wire

// File: hw/lcd_delay_timer.sv
/* Loadable down-counter with a one-cycle done pulse at the end of the delay */

`timescale 1ns/1ps
`default_nettype none

module lcd_delay_timer import lcd_pkg::*; (
	input  wire    CLK,
	input  wire    RST,
	input  logic   start,       // Load cycles and begin counting
	input  delay_t cycles,      // Delay length, at least 1
	output logic   done,        // One cycle, cycles clocks after start
	output logic   busy         // Counting with more than this cycle left
);

	delay_t cnt;                // Cycles left including the current one

	// --------------------------------------------------
	// Counter
	// --------------------------------------------------
	always_ff @(posedge CLK) begin
		if (RST) begin
			cnt <= '0;                                 // Idle
		end else if (start) begin
			cnt <= cycles;                             // First counted cycle follows
		end else if (cnt != '0) begin
			cnt <= cnt - delay_t'(1);                  // Count down
		end
	end

	assign done = (cnt == delay_t'(1));               // Last count
	assign busy = (cnt > delay_t'(1));                 // Still running after this cycle

	// A new delay may begin on the done cycle, never earlier
	a_no_restart: assert property (
		@(posedge CLK) disable iff (RST)
		start |-> !busy
	) else $error("lcd_delay_timer: start while a delay is still running");

endmodule

`default_nettype wire

// File: hw/lcd_bus_writer.sv
/* LCD bus writer: one byte-and-RS request becomes setup time, an E strobe
   and the execution wait, all timed by a single shared delay timer */

`timescale 1ns/1ps
`default_nettype none

module lcd_bus_writer import lcd_pkg::*; (
	input  wire       CLK,
	input  wire       RST,
	input  logic      wr_valid,         // Request offered
	output logic      wr_ready,         // Idle, request can be taken
	input  logic      wr_rs,            // 1 character, 0 instruction
	input  lcd_byte_t wr_data,          // Byte for DB
	input  delay_t    wr_exec_cycles,   // Wait after E falls
	output logic      lcd_rs,
	output lcd_byte_t lcd_db,
	output logic      lcd_e
);

	typedef enum logic [1:0] {
		ST_IDLE,                // Waiting for a request
		ST_SETUP,               // RS/DB valid, E low
		ST_PULSE,               // E high
		ST_EXEC                 // LCD busy executing
	} wr_state_t;

	wr_state_t state;
	logic      accept;              // Handshake this cycle
	logic      tmr_start;
	delay_t    tmr_cycles;
	logic      tmr_done;
	logic      tmr_busy;
	delay_t    exec_cyc_q;          // Exec wait held for the whole write

	assign wr_ready = (state == ST_IDLE);
	assign accept   = wr_valid && wr_ready;

	// --------------------------------------------------
	// Timer control
	// --------------------------------------------------
	// Each phase loads the length of the next one as it ends
	always_comb begin
		tmr_start  = 1'b0;
		tmr_cycles = T_SETUP_CYC;
		case (state)
			ST_IDLE: begin
				tmr_start  = accept;                   // Setup starts with acceptance
				tmr_cycles = T_SETUP_CYC;
			end
			ST_SETUP: begin
				tmr_start  = tmr_done;                 // Then the E pulse
				tmr_cycles = T_PULSE_CYC;
			end
			ST_PULSE: begin
				tmr_start  = tmr_done;                 // Then the exec wait
				tmr_cycles = exec_cyc_q;
			end
			default: begin
				tmr_start  = 1'b0;                     // Exec ends the write
				tmr_cycles = T_SETUP_CYC;
			end
		endcase
	end

	lcd_delay_timer i_lcd_delay_timer (
		.CLK    (CLK),
		.RST    (RST),
		.start  (tmr_start),
		.cycles (tmr_cycles),
		.done   (tmr_done),
		.busy   (tmr_busy)
	);

	// --------------------------------------------------
	// Phase FSM and pins
	// --------------------------------------------------
	always_ff @(posedge CLK) begin
		if (RST) begin
			state  <= ST_IDLE;
			lcd_e  <= 1'b0;
			lcd_rs <= 1'b0;
			lcd_db <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (accept) begin
						state  <= ST_SETUP;
						lcd_rs <= wr_rs;               // Held until next acceptance
						lcd_db <= wr_data;
					end
				end
				ST_SETUP: begin
					if (tmr_done) begin
						state <= ST_PULSE;
						lcd_e <= 1'b1;                 // Strobe rises
					end
				end
				ST_PULSE: begin
					if (tmr_done) begin
						state <= ST_EXEC;
						lcd_e <= 1'b0;                 // Falling edge latches DB
					end
				end
				ST_EXEC: begin
					if (tmr_done)
						state <= ST_IDLE;              // Ready again
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (accept)
			exec_cyc_q <= wr_exec_cycles;          // Payload only
	end

	// Bus must not move under a high strobe
	a_bus_stable: assert property (
		@(posedge CLK) disable iff (RST)
		lcd_e |-> $stable(lcd_db) && $stable(lcd_rs)
	) else $error("lcd_bus_writer: RS/DB changed while E high");

	// An idle writer leaves no delay running behind it
	a_idle_timer: assert property (
		@(posedge CLK) disable iff (RST)
		(state == ST_IDLE) |-> !tmr_busy && !tmr_done
	) else $error("lcd_bus_writer: timer still running in idle");

endmodule

`default_nettype wire

// File: hw/lcd_sequencer.sv
/* LCD sequencer: power-up wait, fixed init instruction table, then
   forwarding of host requests with the choice of execution wait */

`timescale 1ns/1ps
`default_nettype none

module lcd_sequencer import lcd_pkg::*; (
	input  wire       CLK,
	input  wire       RST,
	input  logic      req_valid,        // Host side
	output logic      req_ready,
	input  logic      req_rs,
	input  lcd_byte_t req_data,
	output logic      wr_valid,         // Bus writer side
	input  logic      wr_ready,
	output logic      wr_rs,
	output lcd_byte_t wr_data,
	output delay_t    wr_exec_cycles
);

	localparam int STEP_W = $clog2(INIT_STEPS);

	typedef enum logic [1:0] {
		ST_PWR_GO,              // First cycle out of reset
		ST_PWR_WAIT,            // 50 ms power-up
		ST_INIT,                // Init table playback
		ST_RUN                  // Host requests
	} seq_state_t;

	seq_state_t        state;
	logic [STEP_W-1:0] step;            // Init table index
	logic              last_step;
	lcd_byte_t         init_code;
	delay_t            init_wait;
	logic              pwr_start;
	logic              pwr_done;
	logic              pwr_busy;
	logic              long_exec;       // Host instruction needs 1.64 ms

	// --------------------------------------------------
	// Init table
	// --------------------------------------------------
	always_comb begin
		case (step)
			0: begin
				init_code = CMD_FUNC_SET;                // Wake-up #1
				init_wait = T_INIT1_CYC;
			end
			1, 2: begin
				init_code = CMD_FUNC_SET;                // Wake-up #2 and #3
				init_wait = T_INIT2_CYC;
			end
			3: begin
				init_code = CMD_FUNC_SET;                // Real function set
				init_wait = T_EXEC_SHORT_CYC;
			end
			4: begin
				init_code = CMD_DISP_OFF;
				init_wait = T_EXEC_SHORT_CYC;
			end
			5: begin
				init_code = CMD_CLEAR;
				init_wait = T_EXEC_LONG_CYC;             // Clear is slow
			end
			6: begin
				init_code = CMD_ENTRY;
				init_wait = T_EXEC_SHORT_CYC;
			end
			default: begin
				init_code = CMD_DISP_ON;                 // Cursor and blink on
				init_wait = T_EXEC_SHORT_CYC;
			end
		endcase
	end

	assign last_step = (step == STEP_W'(INIT_STEPS - 1));

	// --------------------------------------------------
	// Power-up timer
	// --------------------------------------------------
	assign pwr_start = (state == ST_PWR_GO);

	lcd_delay_timer i_lcd_delay_timer (
		.CLK    (CLK),
		.RST    (RST),
		.start  (pwr_start),
		.cycles (T_POWERUP_CYC),
		.done   (pwr_done),
		.busy   (pwr_busy)
	);

	// --------------------------------------------------
	// Writer request mux
	// --------------------------------------------------
	assign long_exec = !req_rs && ((req_data == CMD_CLEAR) || (req_data == CMD_HOME));

	always_comb begin
		req_ready      = 1'b0;
		wr_valid       = 1'b0;
		wr_rs          = 1'b0;                       // Init writes are instructions
		wr_data        = init_code;
		wr_exec_cycles = init_wait;
		case (state)
			ST_INIT: wr_valid = 1'b1;
			ST_RUN: begin
				req_ready      = wr_ready;            // Straight through, no buffer
				wr_valid       = req_valid;
				wr_rs          = req_rs;
				wr_data        = req_data;
				wr_exec_cycles = long_exec ? T_EXEC_LONG_CYC : T_EXEC_SHORT_CYC;
			end
			default: wr_valid = 1'b0;
		endcase
	end

	// --------------------------------------------------
	// Sequence FSM
	// --------------------------------------------------
	always_ff @(posedge CLK) begin
		if (RST) begin
			state <= ST_PWR_GO;
			step  <= '0;
		end else begin
			case (state)
				ST_PWR_GO:   state <= ST_PWR_WAIT;        // Timer loads here
				ST_PWR_WAIT: begin
					if (pwr_done)
						state <= ST_INIT;
				end
				ST_INIT: begin
					if (wr_valid && wr_ready) begin
						if (last_step)
							state <= ST_RUN;           // Table done
						else
							step <= step + 1'b1;
					end
				end
				default: state <= ST_RUN;             // Stay in run
			endcase
		end
	end

	// Host stays blocked while the writer runs the last init write
	a_ready_after_init: assert property (
		@(posedge CLK) disable iff (RST)
		(state == ST_INIT) && wr_valid && wr_ready && last_step |=> !req_ready
	) else $error("lcd_sequencer: req_ready before the last init write finished");

	// The power-up wait is always covered by a running timer
	a_pwr_timer: assert property (
		@(posedge CLK) disable iff (RST)
		(state == ST_PWR_WAIT) |-> pwr_busy || pwr_done
	) else $error("lcd_sequencer: power-up timer idle during the wait");

endmodule

`default_nettype wire

// File: hw/lcd_ctrl_top.sv
/* Top level of the write-only HD44780 LCD controller, joining the sequencer
   and the bus writer to the host handshake and the LCD pins */

`timescale 1ns/1ps
`default_nettype none

module lcd_ctrl_top import lcd_pkg::*; (
	input  wire       CLK,              // 24 MHz
	input  wire       RST,
	input  logic      req_valid,        // Host request
	output logic      req_ready,
	input  logic      req_rs,           // 1 character, 0 instruction
	input  lcd_byte_t req_data,
	output logic      lcd_rs,           // LCD pins
	output logic      lcd_rw,
	output logic      lcd_e,
	output lcd_byte_t lcd_db
);

	// --------------------------------------------------
	// Sequencer to writer
	// --------------------------------------------------
	logic      wr_valid;
	logic      wr_ready;
	logic      wr_rs;
	lcd_byte_t wr_data;
	delay_t    wr_exec_cycles;

	assign lcd_rw = 1'b0;                          // Writes only, busy flag never read

	lcd_sequencer i_lcd_sequencer (
		.CLK            (CLK),
		.RST            (RST),
		.req_valid      (req_valid),
		.req_ready      (req_ready),
		.req_rs         (req_rs),
		.req_data       (req_data),
		.wr_valid       (wr_valid),
		.wr_ready       (wr_ready),
		.wr_rs          (wr_rs),
		.wr_data        (wr_data),
		.wr_exec_cycles (wr_exec_cycles)
	);

	lcd_bus_writer i_lcd_bus_writer (
		.CLK            (CLK),
		.RST            (RST),
		.wr_valid       (wr_valid),
		.wr_ready       (wr_ready),
		.wr_rs          (wr_rs),
		.wr_data        (wr_data),
		.wr_exec_cycles (wr_exec_cycles),
		.lcd_rs         (lcd_rs),
		.lcd_db         (lcd_db),
		.lcd_e          (lcd_e)
	);

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
/* Testbench clock and reset generator with a 40 ns period
   and reset held for 3 cycles */

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic CLK,
	output logic RST
);

	// 40 ns period
	initial begin
		CLK = 1'b1;
		forever #20 CLK = ~CLK;
	end

	initial begin
		RST = 1'b1;                                    // Asserted from time zero
		@(negedge CLK);                                // Count only full periods
		repeat (3) @(posedge CLK);
		@(negedge CLK);
		RST <= 1'b0;                                   // Release on a falling edge
	end

endmodule

`default_nettype wire

// File: verif/tb_lcd_ctrl.sv
/* LCD controller testbench: init and host cases from a data file,
   host request driver, bus monitor with strobe and wait checks */

`timescale 1ns/1ps
`default_nettype none

module tb_lcd_ctrl import lcd_pkg::*; ();

	localparam int WAIT_LIMIT = 2_000_000;            // Cycles, covers power-up and init

	wire       CLK;
	wire       RST;
	logic      req_valid;
	logic      req_ready;
	logic      req_rs;
	lcd_byte_t req_data;
	logic      lcd_rs;
	logic      lcd_rw;
	logic      lcd_e;
	lcd_byte_t lcd_db;

	int     exp_rs_q[$];                              // Expected writes in bus order
	int     exp_data_q[$];
	int     exp_wait_q[$];                            // Min cycles after E falls
	int     n_init;
	integer seed;

	// Monitor state, written only at falling edges
	int         cyc;
	int         n_writes;                              // Completed E strobes
	int         rise_cyc;
	int         fall_cyc;
	int         chg_cyc;                               // Last RS/DB change
	logic       e_q;
	logic       ready_q;
	logic [8:0] bus_q;

	tb_clock_gen i_tb_clock_gen (.CLK(CLK), .RST(RST));

	lcd_ctrl_top i_lcd_ctrl_top (
		.CLK       (CLK),
		.RST       (RST),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.req_rs    (req_rs),
		.req_data  (req_data),
		.lcd_rs    (lcd_rs),
		.lcd_rw    (lcd_rw),
		.lcd_e     (lcd_e),
		.lcd_db    (lcd_db)
	);

	// --------------------------------------------------
	// Reporting and checks
	// --------------------------------------------------
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_value(input string name, input string rel, input int exp, input int act);
		$display("FAIL %s: expected %s%0d, actual %0d", name, rel, exp, act);
		abort_run("a checked value was wrong");
	endtask

	task automatic check_eq(input string name, input int exp, input int act);
		assert (act == exp) else report_value(name, "", exp, act);
	endtask

	task automatic check_min(input string name, input int exp, input int act);
		assert (act >= exp) else report_value(name, "at least ", exp, act);
	endtask

	// Wait class letter to cycles
	function automatic int class_cycles(input logic [7:0] cls);
		case (cls)
			"1":     return int'(T_INIT1_CYC);          // 4.1 ms
			"2":     return int'(T_INIT2_CYC);          // 100 us
			"S":     return int'(T_EXEC_SHORT_CYC);
			"L":     return int'(T_EXEC_LONG_CYC);
			default: return -1;
		endcase
	endfunction

	task automatic load_cases();
		int         fd;
		string      line;
		logic [7:0] kind;
		logic [7:0] cls;
		int         rs;
		logic [7:0] data;
		fd = $fopen("verif/lcd_cases.txt", "r");
		if (fd == 0)
			abort_run("cannot open verif/lcd_cases.txt");
		n_init = 0;
		while ($fgets(line, fd) != 0) begin
			if ($sscanf(line, "%c %d %h %c", kind, rs, data, cls) != 4)
				continue;                                // Comment or blank
			if (kind == "I" && exp_rs_q.size() != n_init)
				abort_run("init case after a host case in the data file");
			if (class_cycles(cls) < 0)
				abort_run("unknown wait class in the data file");
			if (kind == "I")
				n_init++;
			exp_rs_q.push_back(rs);
			exp_data_q.push_back(int'(data));
			exp_wait_q.push_back(class_cycles(cls));
		end
		$fclose(fd);
		check_eq("init case count", INIT_STEPS, n_init);
	endtask

	task automatic wait_ready(input int limit);
		int t;
		t = 0;
		while (!req_ready) begin
			@(negedge CLK);
			t++;
			if (t > limit)
				abort_run("timeout waiting for req_ready");
		end
	endtask

	// --------------------------------------------------
	// Bus monitor
	// --------------------------------------------------
	always @(negedge CLK) begin
		if (RST) begin
			cyc      <= 0;
			n_writes <= 0;
			rise_cyc <= 0;
			fall_cyc <= 0;
			chg_cyc  <= 0;
			e_q      <= 1'b0;
			ready_q  <= 1'b0;
			bus_q    <= '0;
		end else begin
			cyc     <= cyc + 1;
			e_q     <= lcd_e;
			ready_q <= req_ready;
			bus_q   <= {lcd_rs, lcd_db};
			if ({lcd_rs, lcd_db} != bus_q)
				chg_cyc <= cyc;
			assert (lcd_rw == 1'b0) else abort_run("lcd_rw went high on a write-only bus");
			if (n_writes < INIT_STEPS)
				assert (!req_ready) else abort_run("req_ready high before init finished");
			if (lcd_e)
				assert ({lcd_rs, lcd_db} == bus_q) else abort_run("RS or DB moved while E high");
			if (lcd_e && !e_q) begin                     // E rise
				rise_cyc <= cyc;
				check_min("setup before E rise", int'(T_SETUP_CYC), cyc - chg_cyc);
				if (n_writes == 0)
					check_min("power-up wait", int'(T_POWERUP_CYC), cyc);
				else
					check_min($sformatf("wait after write %0d", n_writes - 1),
						exp_wait_q[n_writes - 1], cyc - fall_cyc);
			end
			if (!lcd_e && e_q) begin                     // E fall, DB latched here
				fall_cyc <= cyc;
				n_writes <= n_writes + 1;
				assert (n_writes < exp_rs_q.size()) else abort_run("more bus writes than cases");
				check_eq($sformatf("write %0d pulse", n_writes), int'(T_PULSE_CYC), cyc - rise_cyc);
				check_eq($sformatf("write %0d rs", n_writes), exp_rs_q[n_writes], int'(lcd_rs));
				check_eq($sformatf("write %0d data", n_writes), exp_data_q[n_writes], int'(lcd_db));
			end
			if (req_ready && !ready_q && n_writes > 0)   // Writer idle again
				check_min($sformatf("exec before ready %0d", n_writes - 1),
					exp_wait_q[n_writes - 1], cyc - fall_cyc);
		end
	end

	// --------------------------------------------------
	// Host stimulus
	// --------------------------------------------------
	initial begin : stimulus
		int i;
		int gap;
		int t;
		seed      = 32'h702bd7fd;
		req_valid = 1'b0;
		req_rs    = 1'b0;
		req_data  = '0;
		load_cases();
		t = 0;
		while (RST !== 1'b0) begin
			@(negedge CLK);
			t++;
			if (t > 10)
				abort_run("timeout waiting for reset release");
		end
		for (i = n_init; i < exp_rs_q.size(); i++) begin
			gap = $random(seed) & 3;                     // 0 to 3 idle cycles
			repeat (gap) @(negedge CLK);
			req_valid = 1'b1;
			req_rs    = (exp_rs_q[i] != 0);
			req_data  = lcd_byte_t'(exp_data_q[i]);
			wait_ready(WAIT_LIMIT);
			@(negedge CLK);                              // Transfer at the edge between
			req_valid = 1'b0;
		end
		t = 0;
		while (!(n_writes == exp_rs_q.size() && req_ready)) begin
			@(negedge CLK);
			t++;
			if (t > WAIT_LIMIT)
				abort_run("timeout waiting for the last write to finish");
		end
		@(negedge CLK);                                // Monitor sees ready rise
		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/lcd_cases.txt
# kind (I init, H host)  rs  data (hex)  wait after E falls (1 4.1ms, 2 100us, S short, L long)
# init rows come first and list the power-up table in order
I 0 3c 1
I 0 3c 2
I 0 3c 2
I 0 3c S
I 0 08 S
I 0 01 L
I 0 06 S
I 0 0f S
H 1 48 S
H 1 69 S
H 0 01 L
H 1 41 S
H 0 02 L
H 0 c0 S
H 1 7e S
H 0 0c S

// File: tb.f
common/lcd_pkg.sv
hw/lcd_delay_timer.sv
hw/lcd_bus_writer.sv
hw/lcd_sequencer.sv
hw/lcd_ctrl_top.sv
verif/tb_clock_gen.sv
verif/tb_lcd_ctrl.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the LCD controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_lcd_ctrl -f tb.f -o vsim_lcd
if [ $? -ne 0 ]; then
	echo "Verilator build error"
	exit 1
fi

output=$(./obj_dir/vsim_lcd)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Test passed"; then
	exit 0
else
	exit 1
fi
